//--- src.f
hw/soc_map_pkg.sv
hw/soc_bus_pkg.sv
hw/bus_arbiter.sv
hw/block_ram.sv
hw/io_bridge.sv
hw/sys_timer.sv
hw/soc_fabric.sv
bench/soc_fabric_tb.sv

//--- bench/soc_fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_tb
	import soc_map_pkg::*, soc_bus_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 5;
	// 16 writes, 16 reads and the timer wait, with a wide margin
	localparam int CYCLE_LIMIT  = 20000;
	localparam int WAIT_LIMIT   = 64;
	localparam int IRQ_LIMIT    = 400;
	localparam int NUM_WORDS    = 16;
	localparam logic [31:0] LFSR_SEED = 32'd8;
	localparam logic [ADDR_W-1:0] LED_ADDR      = {REGION_BRIDGE, SLOT_LED, 24'h0};
	localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 32'h3000_0000;

	logic       i_clock = 1'b0;
	logic       i_rst_n;
	fetch_req_t fetch_req;
	bus_req_t   data_req;
	bus_req_t   dma_req;
	bus_rsp_t   fetch_rsp;
	bus_rsp_t   data_rsp;
	bus_rsp_t   dma_rsp;
	logic [LED_W-1:0] led;
	logic       timer_irq;

	// Port index 0 data, 1 DMA, 2 fetch
	string             port_name [3] = '{"o_data", "o_dma", "o_fetch"};
	logic [2:0]        req_v;
	logic [2:0]        rdy_v;
	logic [DATA_W-1:0] rdata_v [3];
	logic [DATA_W-1:0] exp_rdata [3];
	logic [2:0]        chk_rdata = '0;
	int                exp_lat [3] = '{0, 0, 0};
	logic [LED_W-1:0]  exp_led = '0;
	logic [DATA_W-1:0] ram_model [RAM_WORDS];
	logic [RAM_IDX_W-1:0] idx_q [$];
	logic [31:0]       lfsr_state = LFSR_SEED;
	int                cycle = 0;

	soc_fabric uut (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_fetch     (fetch_req),
		.o_fetch     (fetch_rsp),
		.i_data      (data_req),
		.o_data      (data_rsp),
		.i_dma       (dma_req),
		.o_dma       (dma_rsp),
		.o_led       (led),
		.o_timer_irq (timer_irq)
	);

	assign req_v      = {fetch_req.req, dma_req.req, data_req.req};
	assign rdy_v      = {fetch_rsp.ready, dma_rsp.ready, data_rsp.ready};
	assign rdata_v[0] = data_rsp.rdata;
	assign rdata_v[1] = dma_rsp.rdata;
	assign rdata_v[2] = fetch_rsp.rdata;

	always #(CLK_PERIOD / 2) i_clock = ~i_clock;

	// ================================================
	// Helpers
	// ================================================
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		report_failure($sformatf("MISMATCH at %0t ns: %s expected %0h, got %0h",
			$time, name, exp, act));
	endtask

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	function automatic logic [ADDR_W-1:0] ram_addr(input logic [RAM_IDX_W-1:0] idx);
		return {REGION_RAM, 16'h0, idx, 2'b00};
	endfunction

	function automatic logic [ADDR_W-1:0] timer_addr(input logic [1:0] ofs);
		return {REGION_BRIDGE, SLOT_TIMER, 20'h0, ofs, 2'b00};
	endfunction

	task automatic start_access(input int m, input logic rw, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata);
		case (m)
			0: data_req <= '{req: 1'b1, rw: rw, addr: addr, wdata: wdata};
			1: dma_req <= '{req: 1'b1, rw: rw, addr: addr, wdata: wdata};
			default: fetch_req <= '{req: 1'b1, addr: addr};
		endcase
	endtask

	task automatic finish_access(input int m, output logic [DATA_W-1:0] rdata);
		int n;
		n = 0;
		do begin
			@(posedge i_clock);
			n++;
		end while (!rdy_v[m] && n < WAIT_LIMIT);
		a_wait_ready: assert (rdy_v[m])
			else report_failure($sformatf("No ready on %s within %0d cycles",
				port_name[m], WAIT_LIMIT));
		rdata = rdata_v[m];
		case (m)
			0: data_req.req <= 1'b0;
			1: dma_req.req <= 1'b0;
			default: fetch_req.req <= 1'b0;
		endcase
		// Bus rule, one idle cycle before the next request
		@(posedge i_clock);
	endtask

	task automatic run_access(input int m, input logic rw, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input int lat, input logic chk,
			input logic [DATA_W-1:0] exp, output logic [DATA_W-1:0] rdata);
		exp_rdata[m] = exp;
		chk_rdata[m] = chk;
		exp_lat[m]   = lat;
		start_access(m, rw, addr, wdata);
		finish_access(m, rdata);
	endtask

	// ================================================
	// Checks
	// ================================================
	always @(posedge i_clock) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			report_failure($sformatf("Timeout, run still going after %0d cycles", CYCLE_LIMIT));
		end
	end

	a_reset_quiet: assert property (@(posedge i_clock)
		(cycle >= 1 && cycle <= RESET_CYCLES) |-> (rdy_v == 3'b000 && led == '0 && !timer_irq))
		else report_mismatch("{ready, o_led, o_timer_irq}", '0,
			$sampled({rdy_v, led, timer_irq}));

	a_one_ready: assert property (@(posedge i_clock) disable iff (!i_rst_n) $onehot0(rdy_v))
		else report_failure("More than one master got ready in the same cycle");

	a_led_value: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		rdy_v[0] |-> led == exp_led)
		else report_mismatch("o_led", $sampled(exp_led), $sampled(led));

	for (genvar m = 0; m < 3; m++) begin : g_master
		int wait_cnt = 0;

		always @(posedge i_clock) begin
			if (req_v[m] && !rdy_v[m]) begin
				wait_cnt <= wait_cnt + 1;
			end else begin
				wait_cnt <= 0;
			end
		end

		a_rdata: assert property (@(posedge i_clock) disable iff (!i_rst_n)
			(rdy_v[m] && chk_rdata[m]) |-> rdata_v[m] == exp_rdata[m])
			else report_mismatch({port_name[m], ".rdata"}, $sampled(exp_rdata[m]),
				$sampled(rdata_v[m]));

		a_latency: assert property (@(posedge i_clock) disable iff (!i_rst_n)
			(rdy_v[m] && exp_lat[m] != 0) |-> wait_cnt == exp_lat[m])
			else report_mismatch({port_name[m], ".ready latency"}, $sampled(exp_lat[m]),
				$sampled(wait_cnt));

		a_single_ready: assert property (@(posedge i_clock) disable iff (!i_rst_n)
			rdy_v[m] |=> !rdy_v[m])
			else report_failure($sformatf("%s ready held for two cycles", port_name[m]));

		// Higher priority masters finish first
		if (m > 0) begin : g_priority
			a_priority: assert property (@(posedge i_clock) disable iff (!i_rst_n)
				rdy_v[m] |-> (req_v & ((3'b001 << m) - 3'b001)) == 3'b000)
				else report_failure($sformatf(
					"%s served ahead of a waiting higher priority master", port_name[m]));
		end
	end

	// ================================================
	// Stimulus
	// ================================================
	initial begin
		logic [31:0]       bits;
		logic [DATA_W-1:0] wd;
		logic [DATA_W-1:0] rd;
		logic [DATA_W-1:0] cmp;
		int                n;
		i_rst_n   = 1'b0;
		fetch_req = '0;
		data_req  = '0;
		dma_req   = '0;
		repeat (RESET_CYCLES) @(posedge i_clock);
		i_rst_n <= 1'b1;
		repeat (2) @(posedge i_clock);

		// RAM writes from the data port, reads spread over all ports
		for (int i = 0; i < NUM_WORDS; i++) begin
			take_bits(RAM_IDX_W, bits);
			idx_q.push_back(bits[RAM_IDX_W-1:0]);
			take_bits(DATA_W, wd);
			ram_model[bits[RAM_IDX_W-1:0]] = wd;
			run_access(0, 1'b1, ram_addr(bits[RAM_IDX_W-1:0]), wd, 2, 1'b0, '0, rd);
		end
		for (int i = 0; i < NUM_WORDS; i++) begin
			run_access(i % 3, 1'b0, ram_addr(idx_q[i]), '0, 2, 1'b1, ram_model[idx_q[i]], rd);
		end

		// All three masters at once
		for (int m = 0; m < 3; m++) begin
			exp_rdata[m] = ram_model[idx_q[m]];
			chk_rdata[m] = 1'b1;
			exp_lat[m]   = (m == 0) ? 2 : 0;
			start_access(m, 1'b0, ram_addr(idx_q[m]), '0);
		end
		for (int m = 0; m < 3; m++) begin
			finish_access(m, rd);
		end

		take_bits(DATA_W, wd);
		exp_led = wd[LED_W-1:0];
		run_access(0, 1'b1, LED_ADDR, wd, 3, 1'b0, '0, rd);
		run_access(0, 1'b0, LED_ADDR, '0, 3, 1'b1, {{(DATA_W-LED_W){1'b0}}, exp_led}, rd);

		// Timer compare and interrupt
		run_access(0, 1'b0, timer_addr(TIMER_REG_COUNT), '0, 4, 1'b0, '0, rd);
		cmp = rd + 200;
		run_access(0, 1'b1, timer_addr(TIMER_REG_COMPARE), cmp, 4, 1'b0, '0, rd);
		a_irq_low: assert (!timer_irq)
			else report_failure("Timer interrupt high right after the compare write");
		run_access(0, 1'b0, timer_addr(TIMER_REG_COMPARE), '0, 4, 1'b1, cmp, rd);
		n = 0;
		while (!timer_irq && n < IRQ_LIMIT) begin
			@(posedge i_clock);
			n++;
		end
		a_irq_rise: assert (timer_irq)
			else report_failure("Timer interrupt did not rise within 400 cycles");
		run_access(0, 1'b0, timer_addr(TIMER_REG_COUNT), '0, 4, 1'b0, '0, rd);
		a_count_past: assert (rd >= cmp)
			else report_mismatch("o_data.rdata (count at least compare)", cmp, rd);
		run_access(0, 1'b1, timer_addr(TIMER_REG_COMPARE), '1, 4, 1'b0, '0, rd);
		a_irq_drop: assert (!timer_irq)
			else report_failure("Timer interrupt still high after compare set to all ones");

		run_access(0, 1'b0, UNMAPPED_ADDR, '0, 2, 1'b1, '0, rd);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/soc_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric
	import soc_map_pkg::*, soc_bus_pkg::*;
(
	input  wire              i_clock,
	input  wire              i_rst_n,

	input  fetch_req_t       i_fetch,
	output bus_rsp_t         o_fetch,
	input  bus_req_t         i_data,
	output bus_rsp_t         o_data,
	input  bus_req_t         i_dma,
	output bus_rsp_t         o_dma,

	output logic [LED_W-1:0] o_led,
	output logic             o_timer_irq
);

	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	bus_req_t bridge_req;
	bus_rsp_t bridge_rsp;
	far_req_t timer_req;
	bus_rsp_t timer_rsp;

	// ================================================
	// Near side
	// ================================================
	bus_arbiter arbiter (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_fetch  (i_fetch),
		.o_fetch  (o_fetch),
		.i_data   (i_data),
		.o_data   (o_data),
		.i_dma    (i_dma),
		.o_dma    (o_dma),
		.o_ram    (ram_req),
		.i_ram    (ram_rsp),
		.o_bridge (bridge_req),
		.i_bridge (bridge_rsp)
	);

	block_ram ram (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	// ================================================
	// Far side
	// ================================================
	io_bridge bridge (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_near  (bridge_req),
		.o_near  (bridge_rsp),
		.o_far   (timer_req),
		.i_far   (timer_rsp),
		.o_led   (o_led)
	);

	sys_timer timer (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_far   (timer_req),
		.o_far   (timer_rsp),
		.o_irq   (o_timer_irq)
	);

endmodule

`default_nettype wire

//--- hw/sys_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sys_timer
	import soc_map_pkg::*, soc_bus_pkg::*;
(
	input  wire      i_clock,
	input  wire      i_rst_n,

	input  far_req_t i_far,
	output bus_rsp_t o_far,

	output logic     o_irq
);

	logic [DATA_W-1:0] count;
	logic [DATA_W-1:0] compare;
	logic              ready_q;
	logic [DATA_W-1:0] rdata_q;
	logic [1:0]        ofs;
	logic              access;

	assign ofs    = i_far.addr[TIMER_OFS_MSB:TIMER_OFS_LSB];
	assign access = i_far.req && !ready_q;

	// ================================================
	// Counter, compare and interrupt
	// ================================================
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			count   <= '0;
			compare <= '1;
			o_irq   <= 1'b0;
		end else begin
			count <= count + 1'b1;
			// Level, stays up until compare moves past count
			o_irq <= count >= compare;
			if (access && i_far.rw && ofs == TIMER_REG_COMPARE) begin
				compare <= i_far.wdata;
			end
		end
	end

	// Register access
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= access;
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			case (ofs)
				TIMER_REG_COUNT:   rdata_q <= count;
				TIMER_REG_COMPARE: rdata_q <= compare;
				default:           rdata_q <= '0;
			endcase
		end
	end

	assign o_far = '{ready: ready_q, rdata: rdata_q};

endmodule

`default_nettype wire

//--- hw/io_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module io_bridge
	import soc_map_pkg::*, soc_bus_pkg::*;
(
	input  wire             i_clock,
	input  wire             i_rst_n,

	input  bus_req_t        i_near,
	output bus_rsp_t        o_near,

	output far_req_t        o_far,
	input  bus_rsp_t        i_far,

	output logic [LED_W-1:0] o_led
);

	far_req_t          far_q;
	logic              active;
	logic              near_ready;
	logic [DATA_W-1:0] near_rdata;
	logic [LED_W-1:0]  led_q;
	logic [3:0]        slot;

	assign slot = far_q.addr[SLOT_MSB:SLOT_LSB];

	// ================================================
	// Far stage and local slots
	// ================================================
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			active     <= 1'b0;
			far_q.req  <= 1'b0;
			near_ready <= 1'b0;
			led_q      <= '0;
		end else begin
			near_ready <= 1'b0;
			if (i_near.req && !active) begin
				active      <= 1'b1;
				far_q.req   <= 1'b1;
				far_q.rw    <= i_near.rw;
				far_q.addr  <= i_near.addr[FAR_ADDR_W-1:0];
				far_q.wdata <= i_near.wdata;
			end else if (far_q.req) begin
				if (slot == SLOT_LED) begin
					if (far_q.rw) begin
						led_q <= far_q.wdata[LED_W-1:0];
					end
					near_ready <= 1'b1;
					near_rdata <= {{(DATA_W-LED_W){1'b0}}, led_q};
					far_q.req  <= 1'b0;
				end else if (slot == SLOT_TIMER) begin
					// Hold far request until the timer answers
					if (i_far.ready) begin
						near_ready <= 1'b1;
						near_rdata <= i_far.rdata;
						far_q.req  <= 1'b0;
					end
				end else begin
					near_ready <= 1'b1;
					near_rdata <= '0;
					far_q.req  <= 1'b0;
				end
			end

			// Near request drops the cycle after ready
			if (near_ready) begin
				active <= 1'b0;
			end
		end
	end

	always_comb begin
		o_far     = far_q;
		o_far.req = far_q.req && (slot == SLOT_TIMER);
	end

	assign o_near = '{ready: near_ready, rdata: near_rdata};
	assign o_led  = led_q;

	// Far request only for a held near access to the timer slot
	a_far_timer_only: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_far.req |-> i_near.req && (i_near.addr[SLOT_MSB:SLOT_LSB] == SLOT_TIMER));

endmodule

`default_nettype wire

//--- hw/block_ram.sv
`timescale 1ns/1ps
`default_nettype none

module block_ram
	import soc_map_pkg::*, soc_bus_pkg::*;
(
	input  wire      i_clock,
	input  wire      i_rst_n,
	input  bus_req_t i_req,
	output bus_rsp_t o_rsp
);

	logic [DATA_W-1:0]    mem [RAM_WORDS];
	logic [RAM_IDX_W-1:0] idx;
	logic                 ready_q;
	logic [DATA_W-1:0]    rdata_q;
	logic                 access;

	assign idx = i_req.addr[WORD_LSB+RAM_IDX_W-1:WORD_LSB];

	// Request stays high through the ready cycle, act once
	assign access = i_req.req && !ready_q;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= access;
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			if (i_req.rw) begin
				mem[idx] <= i_req.wdata;
			end
			rdata_q <= mem[idx];
		end
	end

	assign o_rsp = '{ready: ready_q, rdata: rdata_q};

	a_single_ready: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(o_rsp.ready && i_req.req) |=> !o_rsp.ready);

endmodule

`default_nettype wire

//--- hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
	import soc_map_pkg::*, soc_bus_pkg::*;
(
	input  wire        i_clock,
	input  wire        i_rst_n,

	input  fetch_req_t i_fetch,
	output bus_rsp_t   o_fetch,
	input  bus_req_t   i_data,
	output bus_rsp_t   o_data,
	input  bus_req_t   i_dma,
	output bus_rsp_t   o_dma,

	output bus_req_t   o_ram,
	input  bus_rsp_t   i_ram,
	output bus_req_t   o_bridge,
	input  bus_rsp_t   i_bridge
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_WAIT
	} state_t;

	state_t    state;
	// One-hot: data, dma, fetch
	logic [2:0] gnt;
	bus_req_t  near_q;
	logic      umap_ready;

	logic [3:0] region;
	logic      sel_ram;
	logic      sel_bridge;
	logic      sel_none;
	logic      rsp_ready;
	logic [DATA_W-1:0] rsp_rdata;

	assign region     = near_q.addr[REGION_MSB:REGION_LSB];
	assign sel_ram    = region == REGION_RAM;
	assign sel_bridge = region == REGION_BRIDGE;
	assign sel_none   = !sel_ram && !sel_bridge;

	// ================================================
	// Grant and registered near stage
	// ================================================
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state      <= ST_IDLE;
			gnt        <= 3'b000;
			near_q.req <= 1'b0;
			umap_ready <= 1'b0;
		end else begin
			umap_ready <= 1'b0;
			case (state)
				ST_IDLE: begin
					// Data first, then DMA, then fetch
					if (i_data.req) begin
						gnt    <= 3'b001;
						near_q <= i_data;
						state  <= ST_ISSUE;
					end else if (i_dma.req) begin
						gnt    <= 3'b010;
						near_q <= i_dma;
						state  <= ST_ISSUE;
					end else if (i_fetch.req) begin
						gnt          <= 3'b100;
						near_q.req   <= 1'b1;
						near_q.rw    <= 1'b0;
						near_q.addr  <= i_fetch.addr;
						near_q.wdata <= '0;
						state        <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					// Unmapped region answers on its own
					umap_ready <= sel_none;
					state      <= ST_WAIT;
				end
				ST_WAIT: begin
					if (rsp_ready) begin
						gnt        <= 3'b000;
						near_q.req <= 1'b0;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_comb begin
		o_ram        = near_q;
		o_ram.req    = near_q.req && sel_ram;
		o_bridge     = near_q;
		o_bridge.req = near_q.req && sel_bridge;
	end

	// Response back to the granted master
	always_comb begin
		if (sel_ram) begin
			rsp_ready = i_ram.ready;
			rsp_rdata = i_ram.rdata;
		end else if (sel_bridge) begin
			rsp_ready = i_bridge.ready;
			rsp_rdata = i_bridge.rdata;
		end else begin
			rsp_ready = umap_ready;
			rsp_rdata = '0;
		end
	end

	assign o_data  = '{ready: gnt[0] && rsp_ready, rdata: rsp_rdata};
	assign o_dma   = '{ready: gnt[1] && rsp_ready, rdata: rsp_rdata};
	assign o_fetch = '{ready: gnt[2] && rsp_ready, rdata: rsp_rdata};

	// ================================================
	// Checks
	// ================================================
	a_one_ready: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$onehot0({o_data.ready, o_dma.ready, o_fetch.ready}));

	a_req_granted: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(o_ram.req || o_bridge.req) |-> $onehot(gnt));

	a_ready_to_requester: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(!o_data.ready || i_data.req) && (!o_dma.ready || i_dma.req) &&
		(!o_fetch.ready || i_fetch.req));

endmodule

`default_nettype wire

//--- hw/soc_bus_pkg.sv
`default_nettype none

package soc_bus_pkg;

	import soc_map_pkg::*;

	// Instruction fetch, read only
	typedef struct packed {
		logic              req;
		logic [ADDR_W-1:0] addr;
	} fetch_req_t;

	// Master and near-side request
	typedef struct packed {
		logic              req;
		logic              rw;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	// Ready is a single-cycle pulse, rdata valid with it
	typedef struct packed {
		logic              ready;
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

	// Behind the bridge, address without region nibble
	typedef struct packed {
		logic                  req;
		logic                  rw;
		logic [FAR_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     wdata;
	} far_req_t;

endpackage

`default_nettype wire

//--- hw/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	// ================================================
	// Near side
	// ================================================
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Region select bits
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 28;
	localparam logic [3:0] REGION_RAM    = 4'h1;
	localparam logic [3:0] REGION_BRIDGE = 4'h5;

	// Byte offset inside a word
	localparam int WORD_LSB = 2;

	localparam int RAM_WORDS = 1024;
	localparam int RAM_IDX_W = 10;

	// ================================================
	// Far side
	// ================================================
	localparam int FAR_ADDR_W = 28;
	localparam int SLOT_MSB   = 27;
	localparam int SLOT_LSB   = 24;
	localparam logic [3:0] SLOT_LED   = 4'h0;
	localparam logic [3:0] SLOT_TIMER = 4'h5;

	localparam int LED_W = 10;

	localparam int TIMER_OFS_MSB = 3;
	localparam int TIMER_OFS_LSB = 2;
	localparam logic [1:0] TIMER_REG_COUNT   = 2'd0;
	localparam logic [1:0] TIMER_REG_COMPARE = 2'd1;

endpackage

`default_nettype wire
